//--- src/bus_pkg.sv
/*
  bus_pkg: widths, credit count and shared enums for the memory
  request path between requesters, arbiter and memory channel
*/
package bus_pkg;

  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 64;
  localparam int INSTR_W = 32;

  // outstanding requests allowed on the memory channel
  localparam int MEM_CREDITS = 2;
  localparam int CREDIT_W    = 2;

  // pointer width of the in-order owner queue
  localparam int OWNER_PTR_W = $clog2(MEM_CREDITS);

  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_half  = 2'd1,
    size_word  = 2'd2,
    size_dword = 2'd3
  } access_size_e;

  // who gets the response of an outstanding memory request
  typedef enum logic {
    owner_fetch = 1'b0,
    owner_lsu   = 1'b1
  } req_owner_e;

endpackage

//--- src/timer_pkg.sv
/*
  timer_pkg: address map and reset values of the machine timer
*/
package timer_pkg;

  localparam logic [31:0] TIMER_BASE = 32'h0200_0000;
  // upper address bits decide timer vs memory
  localparam logic [31:0] TIMER_MASK = 32'hffff_0000;

  localparam logic [31:0] MTIME_OFS    = 32'h0000_0000;
  localparam logic [31:0] MTIMECMP_OFS = 32'h0000_0008;

  // compare value that never fires until software writes it
  localparam logic [63:0] MTIMECMP_RESET = 64'hffff_ffff_ffff_ffff;

endpackage

//--- src/mem_timer.sv
/*
  mem_timer: memory-mapped mtime/mtimecmp pair with registered read
  data and a level timer interrupt
*/
module mem_timer
  import bus_pkg::*;
  import timer_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_valid,
  input  logic              i_wen,
  input  logic [ADDR_W-1:0] i_offset,
  input  logic [DATA_W-1:0] i_wdata,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_timer_irq
);

  logic [DATA_W-1:0] mtime;
  logic [DATA_W-1:0] mtimecmp;
  logic              wr_mtime;
  logic              wr_mtimecmp;

  assign wr_mtime    = i_valid & i_wen & (i_offset == MTIME_OFS);
  assign wr_mtimecmp = i_valid & i_wen & (i_offset == MTIMECMP_OFS);

  // free running unless software loads a new value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtime <= '0;
    end else if (wr_mtime) begin
      mtime <= i_wdata;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtimecmp <= MTIMECMP_RESET;
    end else if (wr_mtimecmp) begin
      mtimecmp <= i_wdata;
    end
  end

  // read data lands together with the arbiter's ready
  always_ff @(posedge clk) begin
    if (i_valid) begin
      case (i_offset)
        MTIME_OFS:    o_rdata <= mtime;
        MTIMECMP_OFS: o_rdata <= mtimecmp;
        default:      o_rdata <= '0;
      endcase
    end
  end

  assign o_timer_irq = (mtime >= mtimecmp);

endmodule

//--- src/mem_credit_master.sv
/*
  mem_credit_master: registers issued requests onto the memory channel
  and tracks the credits the memory hands back
*/
module mem_credit_master
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              i_issue_valid,
  input  logic [ADDR_W-1:0] i_issue_addr,
  input  logic              i_issue_wen,
  input  logic [DATA_W-1:0] i_issue_wdata,
  input  access_size_e      i_issue_size,
  output logic              o_can_issue,

  input  logic              i_mem_credit,
  output logic              o_mem_req_valid,
  output logic [ADDR_W-1:0] o_mem_req_addr,
  output logic              o_mem_req_wen,
  output logic [DATA_W-1:0] o_mem_req_wdata,
  output access_size_e      o_mem_req_size
);

  logic [CREDIT_W-1:0] credits;
  logic                issue;

  assign o_can_issue = (credits != '0);
  assign issue       = i_issue_valid & o_can_issue;

  // one credit per request, one back per response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CREDIT_W'(MEM_CREDITS);
    end else begin
      case ({issue, i_mem_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_mem_req_valid <= 1'b0;
    end else begin
      o_mem_req_valid <= issue;
    end
  end

  // request fields only matter while valid is high
  always_ff @(posedge clk) begin
    if (issue) begin
      o_mem_req_addr  <= i_issue_addr;
      o_mem_req_wen   <= i_issue_wen;
      o_mem_req_wdata <= i_issue_wdata;
      o_mem_req_size  <= i_issue_size;
    end
  end

endmodule

//--- src/mem_arbiter.sv
/*
  mem_arbiter: picks fetch or load/store, sends the access to the timer
  or the memory channel and routes responses back in order
*/
module mem_arbiter
  import bus_pkg::*;
  import timer_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,

  input  logic               i_fetch_valid,
  input  logic [ADDR_W-1:0]  i_fetch_addr,
  output logic               o_fetch_ready,
  output logic [INSTR_W-1:0] o_fetch_rdata,

  input  logic               i_lsu_valid,
  input  logic               i_lsu_wen,
  input  logic [ADDR_W-1:0]  i_lsu_addr,
  input  logic [DATA_W-1:0]  i_lsu_wdata,
  input  access_size_e       i_lsu_size,
  output logic               o_lsu_ready,
  output logic [DATA_W-1:0]  o_lsu_rdata,

  output logic               o_issue_valid,
  output logic [ADDR_W-1:0]  o_issue_addr,
  output logic               o_issue_wen,
  output logic [DATA_W-1:0]  o_issue_wdata,
  output access_size_e       o_issue_size,
  input  logic               i_can_issue,
  input  logic               i_mem_rsp_valid,
  input  logic [DATA_W-1:0]  i_mem_rdata,

  output logic               o_timer_valid,
  output logic               o_timer_wen,
  output logic [ADDR_W-1:0]  o_timer_offset,
  output logic [DATA_W-1:0]  o_timer_wdata,
  input  logic [DATA_W-1:0]  i_timer_rdata
);

  logic              fetch_busy;
  logic              lsu_busy;
  logic              fetch_tmr_q;
  logic              lsu_tmr_q;
  logic              pick_lsu;
  logic              pick_valid;
  logic              pick_timer;
  logic [ADDR_W-1:0] pick_addr;
  logic              accept;
  logic              fetch_acc;
  logic              lsu_acc;

  req_owner_e             owner_q [MEM_CREDITS];
  logic [OWNER_PTR_W-1:0] q_wr_ptr;
  logic [OWNER_PTR_W-1:0] q_rd_ptr;
  req_owner_e             head_owner;

  logic [DATA_W-1:0] fetch_raw;
  logic [DATA_W-1:0] lsu_raw;
  logic [DATA_W-1:0] lsu_shifted;

  // load/store has strict priority, a busy port is not considered
  assign pick_lsu   = i_lsu_valid & ~lsu_busy;
  assign pick_valid = pick_lsu | (i_fetch_valid & ~fetch_busy);
  assign pick_addr  = pick_lsu ? i_lsu_addr : i_fetch_addr;
  assign pick_timer = ((pick_addr & TIMER_MASK) == TIMER_BASE);

  // timer always takes the access, memory only with a credit
  assign accept    = pick_valid & (pick_timer | i_can_issue);
  assign lsu_acc   = accept & pick_lsu;
  assign fetch_acc = accept & ~pick_lsu;

  assign o_issue_valid = pick_valid & ~pick_timer;
  assign o_issue_addr  = pick_addr;
  assign o_issue_wen   = pick_lsu & i_lsu_wen;
  assign o_issue_wdata = i_lsu_wdata;
  assign o_issue_size  = pick_lsu ? i_lsu_size : size_word;

  assign o_timer_valid  = pick_valid & pick_timer;
  assign o_timer_wen    = pick_lsu & i_lsu_wen;
  assign o_timer_offset = pick_addr & ~TIMER_MASK;
  assign o_timer_wdata  = i_lsu_wdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_busy  <= 1'b0;
      lsu_busy    <= 1'b0;
      fetch_tmr_q <= 1'b0;
      lsu_tmr_q   <= 1'b0;
    end else begin
      fetch_busy  <= fetch_acc | (fetch_busy & ~o_fetch_ready);
      lsu_busy    <= lsu_acc | (lsu_busy & ~o_lsu_ready);
      fetch_tmr_q <= fetch_acc & pick_timer;
      lsu_tmr_q   <= lsu_acc & pick_timer;
    end
  end

  // owner queue, depth bounded by the credits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
    end else begin
      if (accept & ~pick_timer) begin
        q_wr_ptr <= q_wr_ptr + 1'b1;
      end
      if (i_mem_rsp_valid) begin
        q_rd_ptr <= q_rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept & ~pick_timer) begin
      owner_q[q_wr_ptr] <= pick_lsu ? owner_lsu : owner_fetch;
    end
  end

  assign head_owner = owner_q[q_rd_ptr];

  assign o_fetch_ready = fetch_tmr_q | (i_mem_rsp_valid & (head_owner == owner_fetch));
  assign o_lsu_ready   = lsu_tmr_q | (i_mem_rsp_valid & (head_owner == owner_lsu));

  // memory and timer both return the aligned doubleword
  assign fetch_raw     = fetch_tmr_q ? i_timer_rdata : i_mem_rdata;
  assign o_fetch_rdata = i_fetch_addr[2] ? fetch_raw[63:32] : fetch_raw[31:0];

  assign lsu_raw     = lsu_tmr_q ? i_timer_rdata : i_mem_rdata;
  assign lsu_shifted = lsu_raw >> {i_lsu_addr[2:0], 3'b000};

  // narrow loads are zero-extended
  always_comb begin
    case (i_lsu_size)
      size_byte: o_lsu_rdata = {56'd0, lsu_shifted[7:0]};
      size_half: o_lsu_rdata = {48'd0, lsu_shifted[15:0]};
      size_word: o_lsu_rdata = {32'd0, lsu_shifted[31:0]};
      default:   o_lsu_rdata = lsu_shifted;
    endcase
  end

endmodule

//--- src/mem_subsystem.sv
/*
  mem_subsystem: arbiter, machine timer and credit master for the
  fetch and load/store ports
*/
module mem_subsystem
  import bus_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,

  input  logic               i_fetch_valid,
  input  logic [ADDR_W-1:0]  i_fetch_addr,
  output logic               o_fetch_ready,
  output logic [INSTR_W-1:0] o_fetch_rdata,

  input  logic               i_lsu_valid,
  input  logic               i_lsu_wen,
  input  logic [ADDR_W-1:0]  i_lsu_addr,
  input  logic [DATA_W-1:0]  i_lsu_wdata,
  input  access_size_e       i_lsu_size,
  output logic               o_lsu_ready,
  output logic [DATA_W-1:0]  o_lsu_rdata,

  output logic               o_mem_req_valid,
  output logic [ADDR_W-1:0]  o_mem_req_addr,
  output logic               o_mem_req_wen,
  output logic [DATA_W-1:0]  o_mem_req_wdata,
  output access_size_e       o_mem_req_size,
  input  logic               i_mem_credit,
  input  logic               i_mem_rsp_valid,
  input  logic [DATA_W-1:0]  i_mem_rdata,

  output logic               o_timer_irq
);

  logic              issue_valid;
  logic [ADDR_W-1:0] issue_addr;
  logic              issue_wen;
  logic [DATA_W-1:0] issue_wdata;
  access_size_e      issue_size;
  logic              can_issue;

  logic              timer_valid;
  logic              timer_wen;
  logic [ADDR_W-1:0] timer_offset;
  logic [DATA_W-1:0] timer_wdata;
  logic [DATA_W-1:0] timer_rdata;

  mem_arbiter mem_arbiter_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_fetch_valid   (i_fetch_valid),
    .i_fetch_addr    (i_fetch_addr),
    .o_fetch_ready   (o_fetch_ready),
    .o_fetch_rdata   (o_fetch_rdata),
    .i_lsu_valid     (i_lsu_valid),
    .i_lsu_wen       (i_lsu_wen),
    .i_lsu_addr      (i_lsu_addr),
    .i_lsu_wdata     (i_lsu_wdata),
    .i_lsu_size      (i_lsu_size),
    .o_lsu_ready     (o_lsu_ready),
    .o_lsu_rdata     (o_lsu_rdata),
    .o_issue_valid   (issue_valid),
    .o_issue_addr    (issue_addr),
    .o_issue_wen     (issue_wen),
    .o_issue_wdata   (issue_wdata),
    .o_issue_size    (issue_size),
    .i_can_issue     (can_issue),
    .i_mem_rsp_valid (i_mem_rsp_valid),
    .i_mem_rdata     (i_mem_rdata),
    .o_timer_valid   (timer_valid),
    .o_timer_wen     (timer_wen),
    .o_timer_offset  (timer_offset),
    .o_timer_wdata   (timer_wdata),
    .i_timer_rdata   (timer_rdata)
  );

  mem_timer mem_timer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (timer_valid),
    .i_wen       (timer_wen),
    .i_offset    (timer_offset),
    .i_wdata     (timer_wdata),
    .o_rdata     (timer_rdata),
    .o_timer_irq (o_timer_irq)
  );

  mem_credit_master mem_credit_master_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_issue_valid   (issue_valid),
    .i_issue_addr    (issue_addr),
    .i_issue_wen     (issue_wen),
    .i_issue_wdata   (issue_wdata),
    .i_issue_size    (issue_size),
    .o_can_issue     (can_issue),
    .i_mem_credit    (i_mem_credit),
    .o_mem_req_valid (o_mem_req_valid),
    .o_mem_req_addr  (o_mem_req_addr),
    .o_mem_req_wen   (o_mem_req_wen),
    .o_mem_req_wdata (o_mem_req_wdata),
    .o_mem_req_size  (o_mem_req_size)
  );

endmodule

//--- dv/mem_subsystem_asserts.sv
/*
  mem_subsystem_asserts: credit and ready handshake rules of the
  memory subsystem, bound onto the top level
*/
module mem_subsystem_asserts
  import bus_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic i_fetch_valid,
  input logic i_fetch_ready,
  input logic i_lsu_valid,
  input logic i_lsu_ready,
  input logic i_mem_req_valid,
  input logic i_mem_credit
);

  timeunit 1ns;
  timeprecision 1ps;

  int outstanding;

  // requests seen on the channel minus credits handed back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(i_mem_req_valid) - int'(i_mem_credit);
    end
  end

  req_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    i_mem_req_valid |-> (outstanding < MEM_CREDITS))
    else $error("memory request sent with no credit left");

  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= MEM_CREDITS)
    else $error("more memory requests outstanding than credits");

  fetch_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
    i_fetch_ready |-> i_fetch_valid)
    else $error("fetch ready without fetch valid");

  lsu_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
    i_lsu_ready |-> i_lsu_valid)
    else $error("load/store ready without load/store valid");

endmodule

//--- dv/mem_subsystem_tb.sv
/*
  mem_subsystem_tb: plays the fetch and load/store units against the
  memory subsystem, with a credit-based memory model and a case file
*/
module mem_subsystem_tb
  import bus_pkg::*;
  import timer_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_COLS     = 6;
  localparam int MAX_CASES    = 32;
  localparam int ACCESS_LIMIT = 40;
  localparam int CASE_CYCLES  = 60;
  localparam int OP_WRITE     = 1;
  localparam int OP_PAIR      = 2;
  localparam int OP_HELD      = 3;
  localparam int OP_IRQ       = 4;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               i_fetch_valid;
  logic [ADDR_W-1:0]  i_fetch_addr;
  logic               o_fetch_ready;
  logic [INSTR_W-1:0] o_fetch_rdata;
  logic               i_lsu_valid;
  logic               i_lsu_wen;
  logic [ADDR_W-1:0]  i_lsu_addr;
  logic [DATA_W-1:0]  i_lsu_wdata;
  access_size_e       i_lsu_size;
  logic               o_lsu_ready;
  logic [DATA_W-1:0]  o_lsu_rdata;
  logic               o_mem_req_valid;
  logic [ADDR_W-1:0]  o_mem_req_addr;
  logic               o_mem_req_wen;
  logic [DATA_W-1:0]  o_mem_req_wdata;
  access_size_e       o_mem_req_size;
  logic               i_mem_credit;
  logic               i_mem_rsp_valid;
  logic [DATA_W-1:0]  i_mem_rdata;
  logic               o_timer_irq;

  logic [63:0] cases [MAX_CASES * NUM_COLS];
  int          num_cases;
  int          pass_count;
  int          fail_count;
  integer      seed = 32'h2d9f_d028;

  // memory model state
  logic [63:0] mem [logic [28:0]];
  logic [63:0] rsp_data_q [$];
  int          rsp_due_q [$];
  int          cycle;
  int          owed;
  int          req_count;
  logic        withhold;

  always #10 clk = ~clk;

  mem_subsystem mem_subsystem_inst (.*);

  bind mem_subsystem mem_subsystem_asserts mem_subsystem_asserts_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_fetch_valid   (i_fetch_valid),
    .i_fetch_ready   (o_fetch_ready),
    .i_lsu_valid     (i_lsu_valid),
    .i_lsu_ready     (o_lsu_ready),
    .i_mem_req_valid (o_mem_req_valid),
    .i_mem_credit    (i_mem_credit)
  );

  // unwritten doublewords read back their own address
  function automatic logic [63:0] read_word(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    if (mem.exists(addr[31:3])) begin
      return mem[addr[31:3]];
    end
    return {~base, base};
  endfunction

  function automatic logic [63:0] merge_write(input logic [63:0] old, input logic [63:0] wdata,
                                              input logic [2:0] ofs, input logic [1:0] size);
    logic [63:0] result;
    result = old;
    for (int i = 0; i < (1 << size); i++) begin
      result[(ofs + i) * 8 +: 8] = wdata[i * 8 +: 8];
    end
    return result;
  endfunction

  // in-order responses after 1 to 4 cycles, credit with each unless held
  initial begin : memory_model
    logic [63:0] word;
    int          delay;
    i_mem_credit    = 1'b0;
    i_mem_rsp_valid = 1'b0;
    i_mem_rdata     = '0;
    cycle           = 0;
    owed            = 0;
    req_count       = 0;
    withhold        = 1'b0;
    forever begin
      @(negedge clk);
      cycle++;
      if (o_mem_req_valid === 1'b1) begin
        req_count++;
        word = read_word(o_mem_req_addr);
        if (o_mem_req_wen) begin
          word = merge_write(word, o_mem_req_wdata, o_mem_req_addr[2:0], o_mem_req_size);
          mem[o_mem_req_addr[31:3]] = word;
        end
        delay = 1 + ($unsigned($random(seed)) % 4);
        rsp_data_q.push_back(word);
        rsp_due_q.push_back(cycle + delay);
      end
      i_mem_rsp_valid = 1'b0;
      i_mem_credit    = 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
        i_mem_rsp_valid = 1'b1;
        i_mem_rdata     = rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
        if (withhold) begin
          owed++;
        end else begin
          i_mem_credit = 1'b1;
        end
      end else if (!withhold && owed > 0) begin
        i_mem_credit = 1'b1;
        owed--;
      end
    end
  end

  task automatic run_access(input int port, input logic wen, input logic [1:0] size,
                            input logic [31:0] addr, input logic [63:0] wdata,
                            output logic [63:0] rdata, output int waited,
                            output time seen_at);
    @(negedge clk);
    if (port == 0) begin
      i_fetch_valid = 1'b1;
      i_fetch_addr  = addr;
    end else begin
      i_lsu_valid = 1'b1;
      i_lsu_wen   = wen;
      i_lsu_addr  = addr;
      i_lsu_wdata = wdata;
      i_lsu_size  = access_size_e'(size);
    end
    waited = 0;
    #5;
    while (((port == 0) ? o_fetch_ready : o_lsu_ready) !== 1'b1 && waited < ACCESS_LIMIT) begin
      @(negedge clk);
      #5;
      waited++;
    end
    seen_at = $time;
    rdata   = (port == 0) ? {32'd0, o_fetch_rdata} : o_lsu_rdata;
    @(negedge clk);
    if (port == 0) begin
      i_fetch_valid = 1'b0;
    end else begin
      i_lsu_valid = 1'b0;
    end
  endtask

  task automatic do_case(input int idx, output time done_at);
    int          base;
    int          port;
    int          op;
    int          waited;
    logic [31:0] addr;
    logic [63:0] exp_data;
    logic [63:0] got;
    bit          ok;
    base     = idx * NUM_COLS;
    port     = int'(cases[base]);
    op       = int'(cases[base + 1]);
    addr     = cases[base + 3][31:0];
    exp_data = cases[base + 5];
    ok       = 1'b1;
    if (op == OP_IRQ) begin
      @(negedge clk);
      #5;
      done_at = $time;
      if (o_timer_irq !== exp_data[0]) begin
        $display("error at %0t: case %0d timer irq is %b, expected %b",
                 $time, idx, o_timer_irq, exp_data[0]);
        ok = 1'b0;
      end
    end else begin
      run_access(port, op == OP_WRITE, cases[base + 2][1:0], addr, cases[base + 4],
                 got, waited, done_at);
      if (waited >= ACCESS_LIMIT) begin
        $display("case %0d: the %s port never raised ready", idx,
                 (port == 0) ? "fetch" : "load/store");
        ok = 1'b0;
      end else if (op != OP_WRITE && got !== exp_data) begin
        $display("error at %0t: case %0d read %h, expected %h", $time, idx, got, exp_data);
        ok = 1'b0;
      end else if (port == 1 && (addr & TIMER_MASK) == TIMER_BASE && waited != 1) begin
        $display("error at %0t: case %0d timer ready after %0d cycles, expected 1",
                 $time, idx, waited);
        ok = 1'b0;
      end
    end
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("case %0d (port %0d, op %0d, addr %h) %s", idx, port, op, addr,
             ok ? "ok" : "failed");
  endtask

  // hold credits until both are used, then check the channel stays quiet
  task automatic release_credits();
    int start_count;
    int waited;
    waited = 0;
    while (owed < MEM_CREDITS && waited < ACCESS_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    start_count = req_count;
    repeat (8) @(posedge clk);
    if (owed != MEM_CREDITS) begin
      $display("credits were held back but never ran out");
      fail_count++;
    end else if (req_count != start_count) begin
      $display("error at %0t: memory request sent while no credit was left", $time);
      fail_count++;
    end
    withhold = 1'b0;
  endtask

  initial begin : main_sequence
    int  i;
    time t_a;
    time t_b;
    time lsu_t;
    time fetch_t;
    rst_n         = 1'b0;
    i_fetch_valid = 1'b0;
    i_fetch_addr  = '0;
    i_lsu_valid   = 1'b0;
    i_lsu_wen     = 1'b0;
    i_lsu_addr    = '0;
    i_lsu_wdata   = '0;
    i_lsu_size    = size_byte;
    pass_count    = 0;
    fail_count    = 0;
    $readmemh("dv/mem_cases.txt", cases);
    num_cases = 0;
    while (num_cases < MAX_CASES && !$isunknown(cases[num_cases * NUM_COLS])) begin
      num_cases++;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    if (num_cases == 0) begin
      $display("no cases could be read from dv/mem_cases.txt");
      fail_count++;
    end
    i = 0;
    while (i < num_cases) begin
      if (cases[i * NUM_COLS + 1] == OP_PAIR && i + 1 < num_cases) begin
        fork
          do_case(i, t_a);
          do_case(i + 1, t_b);
        join
        lsu_t   = (cases[i * NUM_COLS] == 1) ? t_a : t_b;
        fetch_t = (cases[i * NUM_COLS] == 1) ? t_b : t_a;
        if (lsu_t > fetch_t) begin
          $display("error at %0t: load/store ready came after fetch ready", $time);
          fail_count++;
        end
        i += 2;
      end else if (cases[i * NUM_COLS + 1] == OP_HELD) begin
        @(posedge clk);
        withhold = 1'b1;
        fork
          begin
            while (i < num_cases && cases[i * NUM_COLS + 1] == OP_HELD) begin
              do_case(i, t_a);
              i++;
            end
          end
          release_credits();
        join
      end else begin
        do_case(i, t_a);
        i++;
      end
    end
    $display("finished: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (num_cases > 0);
    repeat (20 + num_cases * CASE_CYCLES) @(posedge clk);
    $display("watchdog expired before all cases finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- files.f
src/bus_pkg.sv
src/timer_pkg.sv
src/mem_timer.sv
src/mem_credit_master.sv
src/mem_arbiter.sv
src/mem_subsystem.sv
dv/mem_subsystem_asserts.sv
dv/mem_subsystem_tb.sv

//--- dv/mem_cases.txt
// port op size addr wdata expect (port 0 fetch, 1 load/store; op 0 read, 1 write,
// 2 read started with the next line, 3 read with credits held back, 4 timer irq level)
1 4 0 00000000 0 0
1 1 3 00001000 1122334455667788 0
1 0 3 00001000 0 1122334455667788
1 1 0 00001003 ab 0
1 0 0 00001003 0 ab
1 1 1 00001006 beef 0
1 0 1 00001006 0 beef
1 1 2 00001010 cafef00d 0
1 0 2 00001010 0 cafef00d
0 0 2 00001000 0 ab667788
0 0 2 00001004 0 beef3344
1 1 3 00001018 0123456789abcdef 0
1 2 3 00001018 0 0123456789abcdef
0 0 2 00001000 0 ab667788
0 2 2 0000101c 0 01234567
1 0 0 00001019 0 cd
1 3 3 00001000 0 beef3344ab667788
1 3 2 00001010 0 cafef00d
1 3 1 0000101a 0 89ab
1 1 3 02000008 10 0
1 0 3 02000008 0 10
1 4 0 00000000 0 1
1 1 3 02000008 ffffffffffffffff 0
1 4 0 00000000 0 0
